//--- common/intc_defs.svh
/* Widths and counts for the interrupt controller
   Included by the packages, the RTL and the testbench */

`ifndef INTC_DEFS_SVH
`define INTC_DEFS_SVH

// Phase strobes per sampling tick
`define INTC_TICK_DIV 12

// Interrupt sources, in priority order INT0, TIMER, INT1, INT2, SERIAL
`define INTC_NUM_SRC 5

// External lines that go through an edge sampler (INT1, INT2)
`define INTC_NUM_EDGE 2

// Sample history per edge line
`define INTC_HIST_W 4

// CPU command data byte
`define INTC_DATA_W 8

`endif

//--- common/intc_src_pkg.sv
/* Interrupt source indices, request sets and vector addresses
   Shared by the controller RTL and the testbench */

`include "intc_defs.svh"

package intc_src_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Source index, lowest value wins

  typedef enum logic [2:0] {
    INT0   = 3'd0,
    TIMER  = 3'd1,
    INT1   = 3'd2,
    INT2   = 3'd3,
    SERIAL = 3'd4
  } e_int_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Request sets and vectors

  // One bit per source, indexed by e_int_idx
  typedef logic [`INTC_NUM_SRC-1:0] t_int_vec;

  // Entry address put on the data path during interrupt entry
  typedef logic [`INTC_DATA_W-1:0] t_vector;

endpackage

//--- common/intc_cmd_pkg.sv
/* Command opcodes issued by the CPU side to the interrupt controller
   One opcode per cycle, with a data byte alongside */

package intc_cmd_pkg;

  typedef enum logic [2:0] {
    // Idle cycle
    NOP      = 3'd0,
    // Load MK from the data byte
    WRITE_MK = 3'd1,
    EI       = 3'd2,
    DI       = 3'd3,
    // Opcode fetch start, requests get latched
    FETCH    = 3'd4,
    // Interrupt entry done
    ACK      = 3'd5,
    // Skip on flag, index in data[2:0]
    SKIT     = 3'd6
  } e_intc_op;

endpackage

//--- hw/irq_tick_gen.sv
/* Divides the CP1 phase strobe down to the interrupt sampling tick
   One pulse for every INTC_TICK_DIV phase strobes */

`timescale 1ns/100ps

`include "intc_defs.svh"

module irq_tick_gen (
  input  logic CLK,
  input  logic rst_n,
  input  logic phase_tick,
  output logic sample_tick
);

  localparam int CNT_W = $clog2(`INTC_TICK_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`INTC_TICK_DIV - 1);

  logic [CNT_W-1:0] cnt;

  // Tick coincides with the strobe that hits the terminal count
  assign sample_tick = phase_tick && (cnt == CNT_LAST);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (phase_tick) begin
      cnt <= sample_tick ? '0 : cnt + 1'b1;
    end
  end

  a_cnt_range: assert property (@(posedge CLK) disable iff (!rst_n)
    cnt < CNT_W'(`INTC_TICK_DIV))
    else $error("tick divider count out of range: %0d", cnt);

endmodule

//--- hw/int_edge_sampler.sv
/* Edge qualification for one external interrupt line
   Samples on each tick and flags one low sample followed by three highs */

`timescale 1ns/100ps

`include "intc_defs.svh"

module int_edge_sampler (
  input  logic CLK,
  input  logic rst_n,
  input  logic sample_tick,
  input  logic line,
  output logic edge_pulse
);

  localparam int FILL_W = $clog2(`INTC_HIST_W);
  localparam logic [FILL_W-1:0] FILL_FULL = FILL_W'(`INTC_HIST_W - 1);
  // Oldest sample low and all newer ones high
  localparam logic [`INTC_HIST_W-1:0] RISE_PAT = {1'b0, {(`INTC_HIST_W-1){1'b1}}};

  logic [`INTC_HIST_W-1:0] hist;
  logic [`INTC_HIST_W-1:0] hist_next;
  logic [FILL_W-1:0]       fill_cnt;
  logic                    primed;

  assign hist_next = {hist[`INTC_HIST_W-2:0], line};

  // The low sample has to be a real one, not the reset value
  assign primed = (fill_cnt == FILL_FULL);

  assign edge_pulse = sample_tick && primed && (hist_next == RISE_PAT);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      hist     <= '0;
      fill_cnt <= '0;
    end else if (sample_tick) begin
      hist <= hist_next;
      if (!primed) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  // Each tick moves the history by exactly one sample
  a_tick_single: assert property (@(posedge CLK) disable iff (!rst_n)
    sample_tick |=> !sample_tick)
    else $error("sample tick held high for more than one cycle");

endmodule

//--- hw/int_priority_enc.sv
/* Fixed-priority selection over the latched requests
   Gives the one-hot ack set, the vector address and the SKIT flag bit */

`timescale 1ns/100ps

`include "intc_defs.svh"

module int_priority_enc (
  input  intc_src_pkg::t_int_vec latched,
  input  logic [2:0]             sk_index,
  output intc_src_pkg::t_int_vec ack_set,
  output intc_src_pkg::t_vector  vector,
  output logic                   flag
);

  // Software interrupt entry, used when nothing is latched
  localparam intc_src_pkg::t_vector VEC_SOFTI = 8'h60;

  // Lowest set bit has the highest priority
  assign ack_set = latched & (~latched + 1'b1);

  always_comb begin
    case (1'b1)
      ack_set[intc_src_pkg::INT0]:   vector = 8'h04;
      ack_set[intc_src_pkg::TIMER]:  vector = 8'h08;
      ack_set[intc_src_pkg::INT1]:   vector = 8'h10;
      ack_set[intc_src_pkg::INT2]:   vector = 8'h20;
      ack_set[intc_src_pkg::SERIAL]: vector = 8'h40;
      default:                       vector = VEC_SOFTI;
    endcase
  end

  // SKIT test bit, out of range reads as clear
  always_comb begin
    flag = 1'b0;
    if (sk_index < 3'(`INTC_NUM_SRC)) begin
      flag = latched[sk_index];
    end
  end

  // No clock here, so an immediate check on the selection
  always_comb begin
    a_ack_onehot: assert ($onehot0(ack_set))
      else $error("ack set not one-hot: %b", ack_set);
  end

endmodule

//--- hw/int_pending_ctrl.sv
/* Pending, mask, enable and fetch-latch registers of the controller
   Decodes the CPU command and feeds the priority encoder */

`timescale 1ns/100ps

`include "intc_defs.svh"

module int_pending_ctrl (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic [`INTC_NUM_EDGE-1:0]  edge_pulse,
  input  logic                       int0,
  input  logic                       int_timer,
  input  logic                       int_serial,
  input  intc_cmd_pkg::e_intc_op     cmd_op,
  input  logic [`INTC_DATA_W-1:0]    cmd_data,
  output logic                       int_req,
  output intc_src_pkg::t_vector      int_vector,
  output logic                       sk_flag
);

  logic                  int0_q;
  intc_src_pkg::t_int_vec pending;
  intc_src_pkg::t_int_vec pending_next;
  intc_src_pkg::t_int_vec pend_set;
  intc_src_pkg::t_int_vec pend_clr;
  intc_src_pkg::t_int_vec skit_sel;
  intc_src_pkg::t_int_vec src_enable;
  intc_src_pkg::t_int_vec latched;
  intc_src_pkg::t_int_vec ack_set;
  logic [`INTC_DATA_W-1:0] mask;
  logic                  enable;
  logic [2:0]            sk_index;
  logic                  enc_flag;

  assign sk_index = cmd_data[2:0];

  ////////////////////////////////////////////////////////////////////////////
  // Request set and clear terms

  always_comb begin
    pend_set                       = '0;
    pend_set[intc_src_pkg::TIMER]  = int_timer;
    pend_set[intc_src_pkg::INT1]   = edge_pulse[0];
    pend_set[intc_src_pkg::INT2]   = edge_pulse[1];
    pend_set[intc_src_pkg::SERIAL] = int_serial;
  end

  // Flag named by SKIT, none for indices past the last source
  always_comb begin
    skit_sel = '0;
    if (sk_index < 3'(`INTC_NUM_SRC)) begin
      skit_sel[sk_index] = 1'b1;
    end
  end

  always_comb begin
    pend_clr = '0;
    if (cmd_op == intc_cmd_pkg::ACK) begin
      pend_clr = ack_set;
    end else if (cmd_op == intc_cmd_pkg::SKIT) begin
      pend_clr = skit_sel;
    end
  end

  always_comb begin
    // New requests win over a clear in the same cycle
    pending_next = (pending & ~pend_clr) | pend_set;
    // INT0 is a level, it just tracks the input
    pending_next[intc_src_pkg::INT0] = int0_q;
  end

  // Enabled when EI is set and the MK bit is clear
  assign src_enable = {`INTC_NUM_SRC{enable}} & ~mask[`INTC_NUM_SRC-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Registers

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      int0_q  <= 1'b0;
      pending <= '0;
      latched <= '0;
      mask    <= '1;
      enable  <= 1'b0;
      sk_flag <= 1'b0;
    end else begin
      int0_q  <= int0;
      pending <= pending_next;
      case (cmd_op)
        intc_cmd_pkg::WRITE_MK: mask <= cmd_data;
        intc_cmd_pkg::EI:       enable <= 1'b1;
        intc_cmd_pkg::DI:       enable <= 1'b0;
        intc_cmd_pkg::FETCH:    latched <= pending & src_enable;
        // Interrupt entry turns further interrupts off
        intc_cmd_pkg::ACK:      enable <= 1'b0;
        intc_cmd_pkg::SKIT:     sk_flag <= enc_flag;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Priority selection

  int_priority_enc u_prio (
    .latched  (latched),
    .sk_index (sk_index),
    .ack_set  (ack_set),
    .vector   (int_vector),
    .flag     (enc_flag)
  );

  assign int_req = |latched;

  // Entry is only taken for a latched request
  a_ack_has_req: assert property (@(posedge CLK) disable iff (!rst_n)
    (cmd_op == intc_cmd_pkg::ACK) |-> (|latched))
    else $error("ACK with no latched request");

endmodule

//--- hw/intc_top.sv
/* Interrupt controller top level
   Tick divider, edge samplers for INT1/INT2 and the pending/priority logic */

`timescale 1ns/100ps

`include "intc_defs.svh"

module intc_top (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     phase_tick,
  input  logic                     int0,
  input  logic                     int1,
  input  logic                     int2,
  input  logic                     int_timer,
  input  logic                     int_serial,
  input  intc_cmd_pkg::e_intc_op   cmd_op,
  input  logic [`INTC_DATA_W-1:0]  cmd_data,
  output logic                     int_req,
  output intc_src_pkg::t_vector    int_vector,
  output logic                     sk_flag
);

  logic                      sample_tick;
  logic [`INTC_NUM_EDGE-1:0] edge_pulse;
  // Bit 0 is INT1, bit 1 is INT2
  wire  [`INTC_NUM_EDGE-1:0] edge_line = {int2, int1};

  irq_tick_gen u_tick (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .phase_tick  (phase_tick),
    .sample_tick (sample_tick)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Edge interrupt samplers

  for (genvar g = 0; g < `INTC_NUM_EDGE; g++) begin : g_smp
    int_edge_sampler u_smp (
      .CLK         (CLK),
      .rst_n       (rst_n),
      .sample_tick (sample_tick),
      .line        (edge_line[g]),
      .edge_pulse  (edge_pulse[g])
    );
  end

  int_pending_ctrl u_pend (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .edge_pulse (edge_pulse),
    .int0       (int0),
    .int_timer  (int_timer),
    .int_serial (int_serial),
    .cmd_op     (cmd_op),
    .cmd_data   (cmd_data),
    .int_req    (int_req),
    .int_vector (int_vector),
    .sk_flag    (sk_flag)
  );

endmodule

//--- tb/tb_intc_checks.svh
/* Compare tasks and failure reporting for the interrupt controller testbench
   Included inside the testbench module, uses its error counter and row index */

`ifndef TB_INTC_CHECKS_SVH
`define TB_INTC_CHECKS_SVH

////////////////////////////////////////////////////////////////////////////
// Failure reporting

task automatic report_failure();
  $display("tests failed");
  $fatal(1, "simulation stopped after %0d failure(s)", error_count);
endtask

////////////////////////////////////////////////////////////////////////////
// One compare task per kind of result

task automatic check_req(input logic actual, input logic expected);
  check_count++;
  if (actual !== expected) begin
    $display("error at %0t ns, row %0d: int_req = %b, expected %b",
             $time, cur_row, actual, expected);
    error_count++;
    report_failure();
  end
endtask

task automatic check_vector(input intc_src_pkg::t_vector actual,
                            input intc_src_pkg::t_vector expected);
  check_count++;
  if (actual !== expected) begin
    $display("error at %0t ns, row %0d: int_vector = %h, expected %h",
             $time, cur_row, actual, expected);
    error_count++;
    report_failure();
  end
endtask

task automatic check_flag(input logic actual, input logic expected);
  check_count++;
  if (actual !== expected) begin
    $display("error at %0t ns, row %0d: sk_flag = %b, expected %b",
             $time, cur_row, actual, expected);
    error_count++;
    report_failure();
  end
endtask

////////////////////////////////////////////////////////////////////////////
// Expected vector for a set of enabled requests

// Vectors double with each source index, 60 hex for an empty set
function automatic intc_src_pkg::t_vector expected_vector(input intc_src_pkg::t_int_vec set);
  intc_src_pkg::t_vector result;
  result = 8'h60;
  for (int i = `INTC_NUM_SRC - 1; i >= 0; i--) begin
    if (set[i]) begin
      result = 8'h04 << i;
    end
  end
  return result;
endfunction

`endif

//--- tb/tb_intc.sv
/* Testbench for the interrupt controller top level
   Applies a table of commands and line levels and checks req, vector and SKIT flag */

`timescale 1ns/100ps

`include "intc_defs.svh"

module tb_intc;

  // Row kinds
  localparam int K_CHK   = 0;
  localparam int K_SKIP  = 1;
  localparam int K_RAND  = 2;
  localparam int K_MODEL = 3;

  localparam int TICK      = `INTC_TICK_DIV;
  localparam int LOW_WAIT  = 2 * TICK;
  localparam int HIGH_WAIT = 5 * TICK;
  localparam int MAX_ROWS  = 64;

  // Line levels packed as {int0, int1, int2, int_timer, int_serial}
  typedef struct packed {
    intc_cmd_pkg::e_intc_op  op;
    logic [`INTC_DATA_W-1:0] data;
    logic [4:0]              lines;
    logic [7:0]              wait_cyc;
    logic [1:0]              kind;
    intc_src_pkg::t_int_vec  pend;
    logic                    exp_req;
    intc_src_pkg::t_vector   exp_vec;
    logic                    exp_flag;
  } row_t;

  logic                    CLK;
  logic                    rst_n;
  logic                    phase_tick;
  logic                    int0;
  logic                    int1;
  logic                    int2;
  logic                    int_timer;
  logic                    int_serial;
  intc_cmd_pkg::e_intc_op  cmd_op;
  logic [`INTC_DATA_W-1:0] cmd_data;
  logic                    int_req;
  intc_src_pkg::t_vector   int_vector;
  logic                    sk_flag;

  row_t                    rows [0:MAX_ROWS-1];
  int                      n_rows;
  int                      cur_row;
  int                      error_count;
  int                      check_count;
  int                      cycle_cnt;
  int                      cycle_limit;
  integer                  seed;
  logic [`INTC_DATA_W-1:0] last_mask;

  `include "tb_intc_checks.svh"

  intc_top dut0 (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .phase_tick (phase_tick),
    .int0       (int0),
    .int1       (int1),
    .int2       (int2),
    .int_timer  (int_timer),
    .int_serial (int_serial),
    .cmd_op     (cmd_op),
    .cmd_data   (cmd_data),
    .int_req    (int_req),
    .int_vector (int_vector),
    .sk_flag    (sk_flag)
  );

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      report_failure();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table building

  task automatic push_row(input row_t r);
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic add_row(input intc_cmd_pkg::e_intc_op op, input logic [7:0] data,
                         input logic [4:0] lines, input int wait_cyc, input int kind,
                         input logic req, input intc_src_pkg::t_vector vec, input logic flag);
    row_t r;
    r.op       = op;
    r.data     = data;
    r.lines    = lines;
    r.wait_cyc = 8'(wait_cyc);
    r.kind     = 2'(kind);
    r.pend     = '0;
    r.exp_req  = req;
    r.exp_vec  = vec;
    r.exp_flag = flag;
    push_row(r);
  endtask

  // Random mask write followed by a FETCH checked against the known pending set
  task automatic add_mask_trial(input logic [4:0] lines, input intc_src_pkg::t_int_vec pend);
    row_t r;
    add_row(intc_cmd_pkg::WRITE_MK, 8'h00, lines, 1, K_RAND, 1'b0, 8'h60, 1'b0);
    r          = '0;
    r.op       = intc_cmd_pkg::FETCH;
    r.lines    = lines;
    r.wait_cyc = 8'd1;
    r.kind     = 2'(K_MODEL);
    r.pend     = pend;
    push_row(r);
  endtask

  task automatic build_table();
    // Reset state and a FETCH with enable clear and int0 high
    add_row(intc_cmd_pkg::NOP,   8'h00, 5'b00100, 2, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::NOP,   8'h00, 5'b10100, 3, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b10100, 2, K_CHK, 1'b0, 8'h60, 1'b0);
    // INT1 low then high while INT2 stays high from reset
    add_row(intc_cmd_pkg::NOP,      8'h00, 5'b00100, LOW_WAIT,  K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::NOP,      8'h00, 5'b01100, HIGH_WAIT, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::EI,       8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::WRITE_MK, 8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::FETCH,    8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h10, 1'b0);
    add_row(intc_cmd_pkg::ACK,      8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h10, 1'b0);
    add_row(intc_cmd_pkg::EI,       8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h10, 1'b0);
    add_row(intc_cmd_pkg::FETCH,    8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    // Timer and serial pulses plus a qualified INT2 served in priority order
    add_row(intc_cmd_pkg::NOP,   8'h00, 5'b01010, LOW_WAIT,  K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::NOP,   8'h00, 5'b01101, HIGH_WAIT, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h08, 1'b0);
    add_row(intc_cmd_pkg::ACK,   8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h08, 1'b0);
    // Enable stays clear after ACK and nothing gets latched
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::EI,    8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h20, 1'b0);
    add_row(intc_cmd_pkg::ACK,   8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h20, 1'b0);
    add_row(intc_cmd_pkg::EI,    8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h20, 1'b0);
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h40, 1'b0);
    add_row(intc_cmd_pkg::ACK,   8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h40, 1'b0);
    add_row(intc_cmd_pkg::EI,    8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h40, 1'b0);
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    // Mask trials over pending TIMER and SERIAL
    add_row(intc_cmd_pkg::NOP, 8'h00, 5'b01110, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::NOP, 8'h00, 5'b01101, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    for (int i = 0; i < 4; i++) begin
      add_mask_trial(5'b01100, 5'b10010);
    end
    add_row(intc_cmd_pkg::WRITE_MK, 8'hff, 5'b01100, 1, K_SKIP, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::FETCH,    8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::WRITE_MK, 8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    // SKIT test and clear
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h08, 1'b0);
    add_row(intc_cmd_pkg::SKIT,  8'h01, 5'b01100, 1, K_CHK, 1'b1, 8'h08, 1'b1);
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b01100, 1, K_CHK, 1'b1, 8'h40, 1'b1);
    add_row(intc_cmd_pkg::SKIT,  8'h01, 5'b01100, 1, K_CHK, 1'b1, 8'h40, 1'b0);
    add_row(intc_cmd_pkg::SKIT,  8'h04, 5'b01100, 1, K_CHK, 1'b1, 8'h40, 1'b1);
    add_row(intc_cmd_pkg::SKIT,  8'h06, 5'b01100, 1, K_CHK, 1'b1, 8'h40, 1'b0);
    add_row(intc_cmd_pkg::SKIT,  8'h04, 5'b01100, 1, K_CHK, 1'b1, 8'h40, 1'b1);
    add_row(intc_cmd_pkg::SKIT,  8'h05, 5'b01100, 1, K_CHK, 1'b1, 8'h40, 1'b0);
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
    // INT0 level follows the line
    add_row(intc_cmd_pkg::NOP,   8'h00, 5'b11100, 3, K_CHK, 1'b0, 8'h60, 1'b0);
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b11100, 1, K_CHK, 1'b1, 8'h04, 1'b0);
    add_row(intc_cmd_pkg::NOP,   8'h00, 5'b01100, 3, K_CHK, 1'b1, 8'h04, 1'b0);
    add_row(intc_cmd_pkg::FETCH, 8'h00, 5'b01100, 1, K_CHK, 1'b0, 8'h60, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row execution

  task automatic apply_row(input row_t r);
    intc_src_pkg::t_int_vec en_set;
    @(negedge CLK);
    cmd_op   = r.op;
    cmd_data = r.data;
    if (r.kind == 2'(K_RAND)) begin
      last_mask = `INTC_DATA_W'($random(seed));
      cmd_data  = last_mask;
    end
    {int0, int1, int2, int_timer, int_serial} = r.lines;
    @(negedge CLK);
    cmd_op     = intc_cmd_pkg::NOP;
    cmd_data   = '0;
    int_timer  = 1'b0;
    int_serial = 1'b0;
    repeat (r.wait_cyc) @(negedge CLK);
    if (r.kind == 2'(K_CHK)) begin
      check_req(int_req, r.exp_req);
      check_vector(int_vector, r.exp_vec);
      check_flag(sk_flag, r.exp_flag);
    end else if (r.kind == 2'(K_MODEL)) begin
      // Enable is set here and only the mask gates
      en_set = r.pend & ~last_mask[`INTC_NUM_SRC-1:0];
      check_req(int_req, |en_set);
      check_vector(int_vector, expected_vector(en_set));
      check_flag(sk_flag, r.exp_flag);
    end
  endtask

  initial begin
    CLK         = 1'b0;
    rst_n       = 1'b0;
    phase_tick  = 1'b1;
    int0        = 1'b0;
    int1        = 1'b0;
    // INT2 is high from reset on
    int2        = 1'b1;
    int_timer   = 1'b0;
    int_serial  = 1'b0;
    cmd_op      = intc_cmd_pkg::NOP;
    cmd_data    = '0;
    seed        = 35;
    last_mask   = '1;
    n_rows      = 0;
    cur_row     = 0;
    error_count = 0;
    check_count = 0;
    cycle_cnt   = 0;
    build_table();
    cycle_limit = 16 + 100;
    for (int i = 0; i < n_rows; i++) begin
      cycle_limit += int'(rows[i].wait_cyc) + 2;
    end
    repeat (16) @(negedge CLK);
    rst_n = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      cur_row = i;
      apply_row(rows[i]);
    end
    $display("%0d rows applied, %0d checks made", n_rows, check_count);
    if (error_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

//--- src.f
+incdir+common
+incdir+tb
common/intc_src_pkg.sv
common/intc_cmd_pkg.sv
hw/irq_tick_gen.sv
hw/int_edge_sampler.sv
hw/int_priority_enc.sv
hw/int_pending_ctrl.sv
hw/intc_top.sv
tb/tb_intc.sv

//--- Makefile
# Verilator build and run of the interrupt controller testbench
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_intc
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
